// ==== project.f ====
rtl/riscv_priv_pkg.sv
rtl/monitor_log_pkg.sv
rtl/retire_decode.sv
rtl/mode_tracker.sv
rtl/exec_rule_check.sv
rtl/violation_arbiter.sv
rtl/violation_log.sv
rtl/umode_monitor.sv
dv/umode_monitor_chk.sv
dv/umode_monitor_tb.sv

// ==== Makefile ====
# Verilator simulation of the privilege-mode monitor
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= umode_monitor_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/umode_monitor_tb.sv ====
// self-checking testbench, random traces come from a fixed LFSR seed
// retirements are spaced by idle cycles so log entries follow retirement order
`timescale 1ns/100ps
`default_nettype none

module umode_monitor_tb
  import riscv_priv_pkg::*;
  import monitor_log_pkg::*;
();

  localparam int log_depth      = 16;
  localparam int order_w        = 16;
  localparam int addr_w         = $clog2(log_depth);
  localparam int cnt_w          = $clog2(log_depth + 1);
  localparam int reset_cycles   = 16;
  localparam int retire_budget  = 140;
  localparam int n_tests        = 5;
  localparam int timeout_cycles = retire_budget * 8 +
                                  n_tests * (reset_cycles + 14 + 3 * log_depth);

  // csrrs x1 with mstatus and with cycle, addi x1, x0, 1
  localparam logic [31:0] csr_m_word = 32'h3000_20f3;
  localparam logic [31:0] csr_u_word = 32'hc000_20f3;
  localparam logic [31:0] other_word = 32'h0010_0093;

  logic                      clk_i;
  logic                      arst_n;
  logic                      retire_valid;
  logic [order_w-1:0]        retire_order;
  logic [1:0]                retire_mode;
  logic [31:0]               retire_insn;
  logic                      retire_dbg_mode;
  logic                      retire_trap;
  logic                      retire_exception;
  logic [5:0]                retire_cause;
  logic                      retire_intr;
  logic [31:0]               mstatus_rdata;
  logic [31:0]               mstatus_wdata;
  logic [31:0]               mstatus_wmask;
  logic [31:0]               dcsr_rdata;
  logic [addr_w-1:0]         log_rd_addr;
  logic [code_w+order_w-1:0] log_rd_data;
  logic [cnt_w-1:0]          log_count;
  logic                      log_lost;

  logic [31:0]               lfsr = 32'h25d71bf6;
  int                        cycles = 0;
  int                        fail_count = 0;
  int                        gap;
  logic [order_w-1:0]        order_cnt = '0;

  // fields of the next retirement besides mode, class and trap outcome
  logic                      s_dbg;
  logic                      s_intr;
  logic                      s_csr_m;
  logic [31:0]               s_ms_r;
  logic [31:0]               s_ms_w;
  logic [31:0]               s_ms_m;
  logic [31:0]               s_dcsr;

  // model state, 0 first retirement, 1 running, 2 in debug
  logic [1:0]                m_state;
  priv_mode_e                m_exp;
  logic [code_w+order_w-1:0] exp_q [$];

  umode_monitor #(
    .log_depth(log_depth),
    .order_w  (order_w)
  ) DUT (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("simulation did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] insn_word(input insn_class_e cls);
    case (cls)
      ic_mret:   return mret_insn;
      ic_dret:   return dret_insn;
      ic_wfi:    return wfi_insn;
      ic_uret:   return uret_insn;
      ic_ecall:  return ecall_insn;
      ic_ebreak: return ebreak_insn;
      ic_csr:    return s_csr_m ? csr_m_word : csr_u_word;
      default:   return other_word;
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      fail_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic set_defaults();
    s_dbg   = 1'b0;
    s_intr  = 1'b0;
    s_csr_m = 1'b0;
    s_ms_r  = 32'h0000_1800;
    s_ms_w  = 32'h0;
    s_ms_m  = 32'h0;
    s_dcsr  = 32'h0000_0003;
  endtask

  // privilege rules applied to one retirement
  task automatic model_step(input priv_mode_e mode, input insn_class_e cls, input logic trap,
                            input logic [5:0] cause);
    logic [31:0] post;
    logic        user;
    logic        exc;
    logic        ill_ok;
    logic        priv_op;
    logic        dbg_entry;
    logic [3:0]  trk;
    logic [3:0]  rul;
    post      = (s_ms_w & s_ms_m) | (s_ms_r & ~s_ms_m);
    user      = (mode == mode_u);
    exc       = trap && !s_intr;
    ill_ok    = exc && (cause inside {6'd1, 6'd2, 6'd24, 6'd25});
    priv_op   = (cls inside {ic_mret, ic_uret}) || ((cls == ic_wfi) && s_ms_r[21]) ||
                ((cls == ic_csr) && s_csr_m);
    dbg_entry = s_dbg && (m_state == 2'd1);

    trk = 4'd0;
    if (!(mode inside {mode_u, mode_m})) trk = viol_mode_unsupported;
    else if ((m_state == 2'd0) && (mode != mode_m)) trk = viol_reset_mode;
    else if ((m_state != 2'd0) && !s_intr && !dbg_entry && (mode != m_exp)) trk = viol_next_mode;
    else if (s_dbg && (mode != mode_m)) trk = viol_dmode_not_m;

    rul = 4'd0;
    if (post[12:11] inside {2'b01, 2'b10}) rul = viol_mpp_illegal;
    else if (post[8]) rul = viol_spp_set;
    else if (user && post[17]) rul = viol_mprv_in_umode;
    else if (user && (cls == ic_ecall) && !(ill_ok || (exc && (cause == 6'd8))))
      rul = viol_ecall;
    else if (user && (cls == ic_ebreak) && !s_dcsr[12] && !(exc && (cause == 6'd3)))
      rul = viol_ebreak;
    else if (user && priv_op && !ill_ok) rul = viol_priv_insn;

    if (trk != 4'd0) exp_q.push_back({trk, order_cnt});
    if (rul != 4'd0) exp_q.push_back({rul, order_cnt});

    if (trap) m_exp = mode_m;
    else if (cls == ic_mret) m_exp = priv_mode_e'(s_ms_r[12:11]);
    else if (cls == ic_dret) m_exp = priv_mode_e'(s_dcsr[1:0]);
    else m_exp = mode;
    m_state = s_dbg ? 2'd2 : 2'd1;
  endtask

  task automatic retire(input priv_mode_e mode, input insn_class_e cls, input logic trap,
                        input logic [5:0] cause);
    @(posedge clk_i);
    retire_valid     <= 1'b1;
    retire_order     <= order_cnt;
    retire_mode      <= mode;
    retire_insn      <= insn_word(cls);
    retire_dbg_mode  <= s_dbg;
    retire_trap      <= trap;
    retire_exception <= trap && !s_intr;
    retire_cause     <= cause;
    retire_intr      <= s_intr;
    mstatus_rdata    <= s_ms_r;
    mstatus_wdata    <= s_ms_w;
    mstatus_wmask    <= s_ms_m;
    dcsr_rdata       <= s_dcsr;
    model_step(mode, cls, trap, cause);
    order_cnt = order_cnt + 1'b1;
    set_defaults();
    repeat (gap) begin
      @(posedge clk_i);
      retire_valid <= 1'b0;
    end
  endtask

  task automatic reset_dut();
    set_defaults();
    exp_q.delete();
    m_state = 2'd0;
    m_exp   = mode_m;
    @(posedge clk_i);
    retire_valid <= 1'b0;
    log_rd_addr  <= '0;
    arst_n       <= 1'b0;
    repeat (reset_cycles) @(posedge clk_i);
    arst_n <= 1'b1;
    @(posedge clk_i);
  endtask

  task automatic read_log();
    int n;
    n = (exp_q.size() > log_depth) ? log_depth : exp_q.size();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    check("log_count", 32'(log_count), 32'(n));
    check("log_lost", 32'(log_lost), 32'(exp_q.size() > log_depth));
    if (exp_q.size() <= log_depth) begin
      for (int i = 0; i < n; i++) begin
        @(posedge clk_i);
        log_rd_addr <= addr_w'(i);
        @(posedge clk_i);
        @(negedge clk_i);
        check("log entry {code, order}", 32'(log_rd_data), 32'(exp_q[i]));
      end
    end
  endtask

  task automatic to_user();
    s_ms_r = 32'h0;
    retire(mode_m, ic_mret, 1'b0, 6'd0);
  endtask

  // legal step from the current mode, fields outside the rules are random
  task automatic send_legal();
    logic [2:0] pick;
    logic       mpp_u;
    pick   = 3'(rand_bits(3));
    mpp_u  = rand_bits(1) != 0;
    s_ms_r = (rand_bits(32) & ~32'h0002_1900) | (mpp_u ? 32'h0 : 32'h1800);
    s_ms_m = rand_bits(32);
    s_ms_w = s_ms_r ^ (rand_bits(32) & ~32'h0002_1900);
    s_dcsr = rand_bits(32);
    if (m_exp == mode_m) begin
      case (pick)
        3'd0, 3'd1: retire(mode_m, ic_other, 1'b0, 6'd0);
        3'd2: begin
          s_csr_m = 1'b1;
          retire(mode_m, ic_csr, 1'b0, 6'd0);
        end
        3'd3: retire(mode_m, ic_ecall, 1'b1, 6'd11);
        3'd7: begin
          s_intr = 1'b1;
          retire(mode_m, ic_other, 1'b1, 6'd7);
        end
        default: retire(mode_m, ic_mret, 1'b0, 6'd0);
      endcase
    end else begin
      case (pick)
        3'd0: retire(mode_u, ic_other, 1'b0, 6'd0);
        3'd1: retire(mode_u, ic_csr, 1'b0, 6'd0);
        3'd2: retire(mode_u, ic_ecall, 1'b1, 6'd8);
        3'd3: retire(mode_u, ic_ebreak, !s_dcsr[12], s_dcsr[12] ? 6'd0 : 6'd3);
        3'd4: retire(mode_u, ic_wfi, s_ms_r[21], s_ms_r[21] ? 6'd2 : 6'd0);
        3'd5: retire(mode_u, ic_mret, 1'b1, 6'd2);
        3'd6: begin
          s_csr_m = 1'b1;
          retire(mode_u, ic_csr, 1'b1, mpp_u ? 6'd1 : 6'd2);
        end
        default: begin
          s_intr = 1'b1;
          retire(mode_u, ic_other, 1'b1, 6'd7);
        end
      endcase
    end
  endtask

  task automatic mode_violations();
    retire(mode_u, ic_other, 1'b0, 6'd0);
    retire(mode_u, ic_ecall, 1'b1, 6'd8);
    retire(mode_s, ic_other, 1'b1, 6'd2);
    to_user();
    // mret went to U, retiring in M breaks it
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_dbg = 1'b1;
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_dbg  = 1'b1;
    s_dcsr = 32'h0;
    retire(mode_m, ic_dret, 1'b0, 6'd0);
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_dbg = 1'b1;
    retire(mode_u, ic_other, 1'b0, 6'd0);
  endtask

  task automatic field_violations();
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_ms_w = 32'h0000_0800;
    s_ms_m = 32'h0000_1800;
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_ms_r = 32'h0000_1900;
    retire(mode_m, ic_other, 1'b0, 6'd0);
    s_ms_r = 32'h0002_1800;
    retire(mode_m, ic_other, 1'b0, 6'd0);
    to_user();
    s_ms_r = 32'h0002_0000;
    retire(mode_u, ic_other, 1'b0, 6'd0);
  endtask

  task automatic user_insn_rules();
    retire(mode_m, ic_other, 1'b0, 6'd0);
    to_user();
    retire(mode_u, ic_ecall, 1'b1, 6'd8);
    to_user();
    retire(mode_u, ic_ecall, 1'b1, 6'd24);
    to_user();
    retire(mode_u, ic_ecall, 1'b0, 6'd0);
    retire(mode_u, ic_ecall, 1'b1, 6'd3);
    to_user();
    retire(mode_u, ic_ebreak, 1'b1, 6'd3);
    to_user();
    s_dcsr = 32'h0000_1003;
    retire(mode_u, ic_ebreak, 1'b0, 6'd0);
    retire(mode_u, ic_ebreak, 1'b1, 6'd2);
    to_user();
    retire(mode_u, ic_mret, 1'b1, 6'd2);
    to_user();
    retire(mode_u, ic_uret, 1'b1, 6'd2);
    to_user();
    s_ms_r = 32'h0020_0000;
    retire(mode_u, ic_wfi, 1'b1, 6'd2);
    to_user();
    retire(mode_u, ic_wfi, 1'b0, 6'd0);
    s_ms_r = 32'h0020_0000;
    retire(mode_u, ic_wfi, 1'b0, 6'd0);
    s_csr_m = 1'b1;
    retire(mode_u, ic_csr, 1'b1, 6'd2);
    to_user();
    s_csr_m = 1'b1;
    retire(mode_u, ic_csr, 1'b1, 6'd25);
    to_user();
    s_csr_m = 1'b1;
    retire(mode_u, ic_csr, 1'b1, 6'd8);
    to_user();
    s_ms_r = 32'h0;
    retire(mode_u, ic_mret, 1'b0, 6'd0);
    retire(mode_u, ic_csr, 1'b0, 6'd0);
  endtask

  task automatic log_overflow();
    retire(mode_m, ic_other, 1'b0, 6'd0);
    gap = 0;
    repeat (40) begin
      s_ms_r = 32'h0000_1900;
      retire(mode_m, ic_other, 1'b0, 6'd0);
    end
    @(posedge clk_i);
    retire_valid <= 1'b0;
    gap = 6;
  endtask

  initial begin
    clk_i            = 1'b0;
    arst_n           = 1'b0;
    retire_valid     = 1'b0;
    retire_order     = '0;
    retire_mode      = 2'b11;
    retire_insn      = '0;
    retire_dbg_mode  = 1'b0;
    retire_trap      = 1'b0;
    retire_exception = 1'b0;
    retire_cause     = '0;
    retire_intr      = 1'b0;
    mstatus_rdata    = '0;
    mstatus_wdata    = '0;
    mstatus_wmask    = '0;
    dcsr_rdata       = '0;
    log_rd_addr      = '0;
    gap              = 6;

    reset_dut();
    repeat (40) send_legal();
    check("model entries for the clean trace", 32'(exp_q.size()), 32'd0);
    read_log();

    reset_dut();
    mode_violations();
    read_log();

    reset_dut();
    field_violations();
    read_log();

    reset_dut();
    user_insn_rules();
    read_log();

    reset_dut();
    log_overflow();
    read_log();

    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/umode_monitor_chk.sv ====
// concurrent checks on the violation arbiter and the log, bound into both
// a bind target ties off the inputs it lacks, so the checks on those hold trivially there
`timescale 1ns/100ps
`default_nettype none

module umode_monitor_chk #(
  parameter int log_depth = 16
) (
  input logic                           clk_i,
  input logic                           arst_n,
  input logic [1:0]                     pend,
  input logic                           log_wr_stb,
  input logic [$clog2(log_depth+1)-1:0] log_count,
  input logic                           log_lost
);

  // each log write retires exactly one pending slot, never both
  a_single_write: assert property (@(posedge clk_i) disable iff (!arst_n)
      log_wr_stb == $onehot($past(pend) & ~pend))
    else $error("log write does not match exactly one cleared pending slot");

  a_count_max: assert property (@(posedge clk_i) disable iff (!arst_n) log_count <= log_depth)
    else $error("log count above log depth");

  // sticky until reset
  a_lost_sticky: assert property (@(posedge clk_i) disable iff (!arst_n) log_lost |=> log_lost)
    else $error("lost flag cleared without reset");

endmodule

bind violation_arbiter umode_monitor_chk u_arb_chk (
  .clk_i     (clk_i),
  .arst_n    (arst_n),
  .pend      (pend),
  .log_wr_stb(log_wr_stb),
  .log_count ('0),
  .log_lost  (1'b0)
);

bind violation_log umode_monitor_chk #(
  .log_depth(log_depth)
) u_log_chk (
  .clk_i     (clk_i),
  .arst_n    (arst_n),
  .pend      (2'b00),
  .log_wr_stb(1'b0),
  .log_count (log_count),
  .log_lost  (log_lost)
);

`default_nettype wire

// ==== rtl/umode_monitor.sv ====
// privilege-mode monitor for an M+U RISC-V retirement trace
// log_rd_data is {code, order} and arrives one cycle after log_rd_addr
`timescale 1ns/100ps
`default_nettype none

module umode_monitor
  import riscv_priv_pkg::*;
  import monitor_log_pkg::*;
#(
  parameter int log_depth = 16,
  parameter int order_w   = 16
) (
  input  logic                           clk_i,
  input  logic                           arst_n,
  input  logic                           retire_valid,
  input  logic [order_w-1:0]             retire_order,
  input  logic [1:0]                     retire_mode,
  input  logic [31:0]                    retire_insn,
  input  logic                           retire_dbg_mode,
  input  logic                           retire_trap,
  input  logic                           retire_exception,
  input  logic [5:0]                     retire_cause,
  input  logic                           retire_intr,
  input  logic [31:0]                    mstatus_rdata,
  input  logic [31:0]                    mstatus_wdata,
  input  logic [31:0]                    mstatus_wmask,
  input  logic [31:0]                    dcsr_rdata,
  input  logic [$clog2(log_depth)-1:0]   log_rd_addr,
  output logic [code_w+order_w-1:0]      log_rd_data,
  output logic [$clog2(log_depth+1)-1:0] log_count,
  output logic                           log_lost
);

  logic               dec_valid;
  priv_mode_e         dec_mode;
  insn_class_e        dec_class;
  logic [1:0]         dec_csr_priv;
  logic               dec_dbg_mode;
  logic               dec_trap;
  logic               dec_exception;
  exc_cause_e         dec_cause;
  logic               dec_intr;
  logic [31:0]        dec_mstatus_rdata;
  logic [31:0]        dec_mstatus_post;
  logic [31:0]        dec_dcsr_rdata;
  logic [order_w-1:0] dec_order;

  logic               trk_viol_stb;
  violation_e         trk_viol_code;
  logic [order_w-1:0] trk_viol_order;
  logic               rul_viol_stb;
  violation_e         rul_viol_code;
  logic [order_w-1:0] rul_viol_order;

  logic               log_wr_stb;
  violation_e         log_wr_code;
  logic [order_w-1:0] log_wr_order;
  logic               arb_lost_stb;

  // all instance ports carry the same names as the nets above
  retire_decode #(.order_w(order_w)) u_decode (.*);

  mode_tracker #(.order_w(order_w)) u_tracker (.*);

  exec_rule_check #(.order_w(order_w)) u_rules (.*);

  violation_arbiter #(.order_w(order_w)) u_arbiter (.*);

  violation_log #(
    .log_depth(log_depth),
    .order_w  (order_w)
  ) u_log (.*);

endmodule

`default_nettype wire

// ==== rtl/violation_log.sv ====
// append-only violation log, keeps the first log_depth entries
// log_depth should be a power of two so every read address is backed
`timescale 1ns/100ps
`default_nettype none

module violation_log
  import monitor_log_pkg::*;
#(
  parameter int log_depth = 16,
  parameter int order_w   = 16
) (
  input  logic                           clk_i,
  input  logic                           arst_n,
  input  logic                           log_wr_stb,
  input  violation_e                     log_wr_code,
  input  logic [order_w-1:0]             log_wr_order,
  input  logic                           arb_lost_stb,
  input  logic [$clog2(log_depth)-1:0]   log_rd_addr,
  output logic [code_w+order_w-1:0]      log_rd_data,
  output logic [$clog2(log_depth+1)-1:0] log_count,
  output logic                           log_lost
);

  localparam int cnt_w  = $clog2(log_depth + 1);
  localparam int addr_w = $clog2(log_depth);

  logic [code_w+order_w-1:0] mem [log_depth];
  logic                      full;
  logic                      wr_en;

  assign full  = (log_count == cnt_w'(log_depth));
  assign wr_en = log_wr_stb && !full;

  // count doubles as the write pointer
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      log_count <= '0;
      log_lost  <= 1'b0;
    end else begin
      if (wr_en) log_count <= log_count + 1'b1;
      if ((log_wr_stb && full) || arb_lost_stb) log_lost <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[log_count[addr_w-1:0]] <= {log_wr_code, log_wr_order};
    log_rd_data <= mem[log_rd_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/violation_arbiter.sv ====
// one pending slot per checker, no back-pressure on the strobes
// a strobe that finds its slot still pending is dropped and flagged as lost
`timescale 1ns/100ps
`default_nettype none

module violation_arbiter
  import monitor_log_pkg::*;
#(
  parameter int order_w = 16
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               trk_viol_stb,
  input  violation_e         trk_viol_code,
  input  logic [order_w-1:0] trk_viol_order,
  input  logic               rul_viol_stb,
  input  violation_e         rul_viol_code,
  input  logic [order_w-1:0] rul_viol_order,
  output logic               log_wr_stb,
  output violation_e         log_wr_code,
  output logic [order_w-1:0] log_wr_order,
  output logic               arb_lost_stb
);

  logic [1:0]         in_stb;
  logic [1:0]         pend;
  logic [1:0]         grant;
  logic               last_grant;
  violation_e         in_code [2];
  violation_e         pend_code [2];
  logic [order_w-1:0] in_order [2];
  logic [order_w-1:0] pend_order [2];

  assign in_stb      = {rul_viol_stb, trk_viol_stb};
  assign in_code[0]  = trk_viol_code;
  assign in_code[1]  = rul_viol_code;
  assign in_order[0] = trk_viol_order;
  assign in_order[1] = rul_viol_order;

  // slot 0 wins unless slot 1 is waiting and slot 0 went last
  assign grant[0] = pend[0] && (!pend[1] || last_grant);
  assign grant[1] = pend[1] && !grant[0];

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      pend         <= 2'b00;
      last_grant   <= 1'b1;
      log_wr_stb   <= 1'b0;
      arb_lost_stb <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (grant[i]) pend[i] <= 1'b0;
        if (in_stb[i] && !pend[i]) pend[i] <= 1'b1;
      end
      log_wr_stb   <= |grant;
      arb_lost_stb <= |(in_stb & pend);
      if (|grant) last_grant <= grant[1];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (in_stb[i] && !pend[i]) begin
        pend_code[i]  <= in_code[i];
        pend_order[i] <= in_order[i];
      end
    end
    if (|grant) begin
      log_wr_code  <= grant[1] ? pend_code[1] : pend_code[0];
      log_wr_order <= grant[1] ? pend_order[1] : pend_order[0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exec_rule_check.sv ====
// mstatus field rules and u-mode instruction rules
// fields are judged on the post-write mstatus value
`timescale 1ns/100ps
`default_nettype none

module exec_rule_check
  import riscv_priv_pkg::*;
  import monitor_log_pkg::*;
#(
  parameter int order_w = 16
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               dec_valid,
  input  priv_mode_e         dec_mode,
  input  insn_class_e        dec_class,
  input  logic [1:0]         dec_csr_priv,
  input  logic               dec_trap,
  input  logic               dec_exception,
  input  exc_cause_e         dec_cause,
  input  logic [31:0]        dec_mstatus_rdata,
  input  logic [31:0]        dec_mstatus_post,
  input  logic [31:0]        dec_dcsr_rdata,
  input  logic [order_w-1:0] dec_order,
  output logic               rul_viol_stb,
  output violation_e         rul_viol_code,
  output logic [order_w-1:0] rul_viol_order
);

  violation_e code_d;
  logic       in_u;
  logic       exc_taken;
  logic       hi_fault;
  logic       illegal_ok;
  logic       priv_op;
  logic       bad_mpp;
  logic       bad_spp;
  logic       bad_mprv;
  logic       bad_ecall;
  logic       bad_ebreak;
  logic       bad_priv;

  always_comb begin
    in_u      = (dec_mode == mode_u);
    exc_taken = dec_trap && dec_exception;
    // fetch side faults outrank illegal instruction and ecall
    hi_fault   = dec_cause inside {cause_insn_fault, cause_insn_bus, cause_insn_parity};
    illegal_ok = exc_taken && (hi_fault || (dec_cause == cause_illegal));
    priv_op    = (dec_class inside {ic_mret, ic_uret}) ||
                 ((dec_class == ic_wfi) && dec_mstatus_rdata[tw_pos]) ||
                 ((dec_class == ic_csr) && (dec_csr_priv != 2'b00));

    bad_mpp  = !(dec_mstatus_post[mpp_pos +: 2] inside {mode_u, mode_m});
    bad_spp  = dec_mstatus_post[spp_pos];
    bad_mprv = in_u && dec_mstatus_post[mprv_pos];
    bad_ecall = in_u && (dec_class == ic_ecall) &&
                !(illegal_ok || (exc_taken && (dec_cause == cause_ecall_u)));
    bad_ebreak = in_u && (dec_class == ic_ebreak) && !dec_dcsr_rdata[ebreaku_pos] &&
                 !(exc_taken && (dec_cause == cause_breakpoint));
    bad_priv = in_u && priv_op && !illegal_ok;

    if (bad_mpp) code_d = viol_mpp_illegal;
    else if (bad_spp) code_d = viol_spp_set;
    else if (bad_mprv) code_d = viol_mprv_in_umode;
    else if (bad_ecall) code_d = viol_ecall;
    else if (bad_ebreak) code_d = viol_ebreak;
    else code_d = viol_priv_insn;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      rul_viol_stb <= 1'b0;
    end else begin
      rul_viol_stb <= dec_valid &&
                      (bad_mpp || bad_spp || bad_mprv || bad_ecall || bad_ebreak || bad_priv);
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid) begin
      rul_viol_code  <= code_d;
      rul_viol_order <= dec_order;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mode_tracker.sv ====
// tracks the mode the next retirement must run in
// debug entry is not compared, dmode_not_m covers the first debug retirement
`timescale 1ns/100ps
`default_nettype none

module mode_tracker
  import riscv_priv_pkg::*;
  import monitor_log_pkg::*;
#(
  parameter int order_w = 16
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               dec_valid,
  input  priv_mode_e         dec_mode,
  input  insn_class_e        dec_class,
  input  logic               dec_dbg_mode,
  input  logic               dec_trap,
  input  logic               dec_intr,
  input  logic [31:0]        dec_mstatus_rdata,
  input  logic [31:0]        dec_dcsr_rdata,
  input  logic [order_w-1:0] dec_order,
  output logic               trk_viol_stb,
  output violation_e         trk_viol_code,
  output logic [order_w-1:0] trk_viol_order
);

  typedef enum logic [1:0] {
    st_first,
    st_run,
    st_dbg
  } trk_state_e;

  trk_state_e state;
  priv_mode_e exp_mode;
  priv_mode_e exp_next;
  violation_e code_d;
  logic       dbg_entry;
  logic       bad_mode;
  logic       bad_reset;
  logic       bad_next;
  logic       bad_dmode;

  always_comb begin
    dbg_entry = (state == st_run) && dec_dbg_mode;
    bad_mode  = !(dec_mode inside {mode_u, mode_m});
    bad_reset = (state == st_first) && (dec_mode != mode_m);
    bad_next  = (state != st_first) && !dec_intr && !dbg_entry && (dec_mode != exp_mode);
    bad_dmode = dec_dbg_mode && (dec_mode != mode_m);

    if (dec_trap) exp_next = mode_m;
    else if (dec_class == ic_mret) exp_next = priv_mode_e'(dec_mstatus_rdata[mpp_pos +: 2]);
    else if (dec_class == ic_dret) exp_next = priv_mode_e'(dec_dcsr_rdata[prv_pos +: 2]);
    else exp_next = dec_mode;

    if (bad_mode) code_d = viol_mode_unsupported;
    else if (bad_reset) code_d = viol_reset_mode;
    else if (bad_next) code_d = viol_next_mode;
    else code_d = viol_dmode_not_m;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      state        <= st_first;
      exp_mode     <= mode_m;
      trk_viol_stb <= 1'b0;
    end else begin
      trk_viol_stb <= dec_valid && (bad_mode || bad_reset || bad_next || bad_dmode);
      if (dec_valid) begin
        state    <= dec_dbg_mode ? st_dbg : st_run;
        exp_mode <= exp_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid) begin
      trk_viol_code  <= code_d;
      trk_viol_order <= dec_order;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/retire_decode.sv ====
// one-cycle decode stage shared by both checkers
// payload only loads on retire_valid, dec_valid qualifies it
`timescale 1ns/100ps
`default_nettype none

module retire_decode
  import riscv_priv_pkg::*;
#(
  parameter int order_w = 16
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               retire_valid,
  input  logic [order_w-1:0] retire_order,
  input  logic [1:0]         retire_mode,
  input  logic [31:0]        retire_insn,
  input  logic               retire_dbg_mode,
  input  logic               retire_trap,
  input  logic               retire_exception,
  input  logic [5:0]         retire_cause,
  input  logic               retire_intr,
  input  logic [31:0]        mstatus_rdata,
  input  logic [31:0]        mstatus_wdata,
  input  logic [31:0]        mstatus_wmask,
  input  logic [31:0]        dcsr_rdata,
  output logic               dec_valid,
  output priv_mode_e         dec_mode,
  output insn_class_e        dec_class,
  output logic [1:0]         dec_csr_priv,
  output logic               dec_dbg_mode,
  output logic               dec_trap,
  output logic               dec_exception,
  output exc_cause_e         dec_cause,
  output logic               dec_intr,
  output logic [31:0]        dec_mstatus_rdata,
  output logic [31:0]        dec_mstatus_post,
  output logic [31:0]        dec_dcsr_rdata,
  output logic [order_w-1:0] dec_order
);

  insn_class_e insn_class;
  logic        is_system;

  always_comb begin
    is_system = ((retire_insn & opcode_mask) == system_opcode);
    if (retire_insn == mret_insn) insn_class = ic_mret;
    else if (retire_insn == dret_insn) insn_class = ic_dret;
    else if (retire_insn == wfi_insn) insn_class = ic_wfi;
    else if (retire_insn == uret_insn) insn_class = ic_uret;
    else if (retire_insn == ecall_insn) insn_class = ic_ecall;
    else if (retire_insn == ebreak_insn) insn_class = ic_ebreak;
    else if (is_system && csr_funct3_set[retire_insn[funct3_pos +: 3]]) insn_class = ic_csr;
    else insn_class = ic_other;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= retire_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_valid) begin
      dec_mode          <= priv_mode_e'(retire_mode);
      dec_class         <= insn_class;
      // privilege level sits in csr address bits 9:8
      dec_csr_priv      <= (insn_class == ic_csr) ? retire_insn[csr_priv_pos +: 2] : 2'b00;
      dec_dbg_mode      <= retire_dbg_mode;
      dec_trap          <= retire_trap;
      dec_exception     <= retire_exception;
      dec_cause         <= exc_cause_e'(retire_cause);
      dec_intr          <= retire_intr;
      dec_mstatus_rdata <= mstatus_rdata;
      dec_mstatus_post  <= (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);
      dec_dcsr_rdata    <= dcsr_rdata;
      dec_order         <= retire_order;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/monitor_log_pkg.sv ====
// violation codes, numbered by priority, lowest wins within a checker
`default_nettype none

package monitor_log_pkg;

  localparam int code_w = 4;

  typedef enum logic [code_w-1:0] {
    viol_mode_unsupported = 4'd1,
    viol_reset_mode       = 4'd2,
    viol_next_mode        = 4'd3,
    viol_dmode_not_m      = 4'd4,
    viol_mpp_illegal      = 4'd5,
    viol_spp_set          = 4'd6,
    viol_mprv_in_umode    = 4'd7,
    viol_ecall            = 4'd8,
    viol_ebreak           = 4'd9,
    viol_priv_insn        = 4'd10
  } violation_e;

endpackage

`default_nettype wire

// ==== rtl/riscv_priv_pkg.sv ====
// privileged architecture constants for an M+U only core
// instruction words are full 32-bit matches, compressed forms are not decoded
`default_nettype none

package riscv_priv_pkg;

  typedef enum logic [1:0] {
    mode_u = 2'b00,
    mode_s = 2'b01,
    mode_m = 2'b11
  } priv_mode_e;

  typedef enum logic [3:0] {
    ic_other,
    ic_mret,
    ic_dret,
    ic_wfi,
    ic_uret,
    ic_ecall,
    ic_ebreak,
    ic_csr
  } insn_class_e;

  typedef enum logic [5:0] {
    cause_insn_fault  = 6'd1,
    cause_illegal     = 6'd2,
    cause_breakpoint  = 6'd3,
    cause_ecall_u     = 6'd8,
    cause_insn_bus    = 6'd24,
    cause_insn_parity = 6'd25
  } exc_cause_e;

  localparam logic [31:0] mret_insn   = 32'h3020_0073;
  localparam logic [31:0] dret_insn   = 32'h7b20_0073;
  localparam logic [31:0] wfi_insn    = 32'h1050_0073;
  localparam logic [31:0] uret_insn   = 32'h0020_0073;
  localparam logic [31:0] ecall_insn  = 32'h0000_0073;
  localparam logic [31:0] ebreak_insn = 32'h0010_0073;

  localparam logic [31:0] system_opcode = 32'h0000_0073;
  localparam logic [31:0] opcode_mask   = 32'h0000_007f;
  // one bit per funct3 value, set for csrrw/s/c and the immediate forms
  localparam logic [31:0] csr_funct3_set = 32'h0000_00ee;
  localparam int funct3_pos   = 12;
  localparam int csr_priv_pos = 28;

  // mstatus
  localparam int mpp_pos  = 11;
  localparam int spp_pos  = 8;
  localparam int mprv_pos = 17;
  localparam int tw_pos   = 21;

  // dcsr
  localparam int prv_pos     = 0;
  localparam int ebreaku_pos = 12;

endpackage

`default_nettype wire
